// File: common/issue_macros.svh
// Issue stage widths shared by the decode, issue and scoreboard blocks
`ifndef ISSUE_MACROS_SVH
`define ISSUE_MACROS_SVH

// Data and PC width
`define XLEN 32

// Architectural integer registers
`define NUM_REGS 32

// Register address width, log2 of NUM_REGS
`define REG_ADDR_W 5

// Instruction tag carried from fetch to the units
`define ID_WIDTH 3

`endif

// File: common/issue_pkg.sv
// Issue package with opcode, unit, exception and privilege types for decode and issue
package issue_pkg;

    // RV32 major opcodes used by the stage
    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        SYSTEM = 7'b1110011
    } opcode_t;

    // Bit positions in the unit one-hot vectors
    typedef enum logic [1:0] {
        ALU_ID = 2'd0,
        MUL_ID = 2'd1,
        LS_ID  = 2'd2
    } unit_id_t;

    localparam int NUM_UNITS = 3;

    typedef enum logic [3:0] {
        FETCH_FAULT  = 4'd1,
        ILLEGAL_INST = 4'd2,
        BREAK        = 4'd3,
        ECALL_U      = 4'd8,
        ECALL_S      = 4'd9,
        ECALL_M      = 4'd11
    } exc_code_t;

    typedef enum logic [1:0] {
        USER       = 2'd0,
        SUPERVISOR = 2'd1,
        MACHINE    = 2'd3
    } priv_t;

    // Register view of an instruction word
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_t    opcode;
    } r_fields_t;

    // Upper immediate view, used by the constant ALU
    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        opcode_t     opcode;
    } u_fields_t;

    typedef union packed {
        r_fields_t r;
        u_fields_t u;
    } instr_word_u;

endpackage

// File: decode_issue/unit_decoder.sv
// Unit decoder mapping an RV32IM word to its execution unit and register use
`timescale 1ns/1ns

module unit_decoder (
    input  issue_pkg::instr_word_u           instruction,
    output logic [issue_pkg::NUM_UNITS-1:0] unit_needed,
    output logic                             uses_rs1,
    output logic                             uses_rs2,
    output logic                             uses_rd,
    output logic                             is_ecall,
    output logic                             is_ebreak
);
    import issue_pkg::*;

    r_fields_t fields;
    logic      sys_fields_zero;

    assign fields = instruction.r;

    // ECALL and EBREAK differ only in rs2
    assign sys_fields_zero = (fields.funct7 == 7'd0) && (fields.rs1 == 5'd0) &&
                             (fields.funct3 == 3'd0) && (fields.rd == 5'd0);
    assign is_ecall  = (fields.opcode == SYSTEM) && sys_fields_zero && (fields.rs2 == 5'd0);
    assign is_ebreak = (fields.opcode == SYSTEM) && sys_fields_zero && (fields.rs2 == 5'd1);

    always_comb begin
        unit_needed = '0;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        uses_rd = 1'b0;
        case (fields.opcode)
            // U and J formats write rd only
            LUI, AUIPC, JAL: begin
                unit_needed[ALU_ID] = 1'b1;
                uses_rd = 1'b1;
            end
            JALR, OP_IMM: begin
                unit_needed[ALU_ID] = 1'b1;
                uses_rs1 = 1'b1;
                uses_rd = 1'b1;
            end
            BRANCH: begin
                unit_needed[ALU_ID] = 1'b1;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            OP: begin
                // funct7 of 1 selects the M extension
                if (fields.funct7 == 7'd1) begin
                    unit_needed[MUL_ID] = 1'b1;
                end else begin
                    unit_needed[ALU_ID] = 1'b1;
                end
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                uses_rd = 1'b1;
            end
            LOAD: begin
                unit_needed[LS_ID] = 1'b1;
                uses_rs1 = 1'b1;
                uses_rd = 1'b1;
            end
            STORE: begin
                unit_needed[LS_ID] = 1'b1;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            // SYSTEM and unknown opcodes need no unit
            default: begin
                unit_needed = '0;
            end
        endcase
    end

endmodule

// File: decode_issue/decode_and_issue.sv
// Decode and issue stage with issue register, unit select, constant ALU and early exceptions
`timescale 1ns/1ns
`include "issue_macros.svh"

module decode_and_issue (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             decode_valid,
    input  logic [`XLEN-1:0]                 decode_pc,
    input  issue_pkg::instr_word_u           decode_instruction,
    input  logic [`ID_WIDTH-1:0]             decode_id,
    input  logic                             decode_fetch_ok,
    input  logic [issue_pkg::NUM_UNITS-1:0] unit_needed,
    input  logic                             uses_rs1,
    input  logic                             uses_rs2,
    input  logic                             uses_rd,
    input  logic                             is_ecall,
    input  logic                             is_ebreak,
    input  logic                             rs1_busy,
    input  logic                             rs2_busy,
    input  logic [issue_pkg::NUM_UNITS-1:0] unit_ready,
    input  logic                             flush,
    input  logic                             issue_hold,
    input  issue_pkg::priv_t                 priv,
    output logic                             decode_advance,
    output logic [`REG_ADDR_W-1:0]           issue_rs1,
    output logic [`REG_ADDR_W-1:0]           issue_rs2,
    output logic                             sb_set_en,
    output logic [`REG_ADDR_W-1:0]           sb_set_rd,
    output logic [issue_pkg::NUM_UNITS-1:0] unit_request,
    output logic [`ID_WIDTH-1:0]             issue_id,
    output logic [`REG_ADDR_W-1:0]           issue_rd,
    output logic [`XLEN-1:0]                 constant_alu,
    output logic                             exception_valid,
    output issue_pkg::exc_code_t             exception_code,
    output logic [`XLEN-1:0]                 exception_tval,
    output logic [`XLEN-1:0]                 exception_pc
);
    import issue_pkg::*;

    logic                 issue_stage_ready;
    logic                 stage_valid;
    logic [`XLEN-1:0]     issue_pc;
    logic [NUM_UNITS-1:0] issue_unit;
    logic                 issue_uses_rs1;
    logic                 issue_uses_rs2;
    logic                 issue_uses_rd;
    logic                 operands_ready;
    logic [NUM_UNITS-1:0] issue_to;
    logic                 exception_pending;
    logic                 exception_raised;
    logic                 new_exception;
    logic                 illegal_pattern;
    exc_code_t            ecall_code;
    exc_code_t            decode_code;
    logic [`XLEN-1:0]     decode_tval;
    logic [`XLEN-1:0]     upper_imm;

    // Stage accepts when empty or when its occupant leaves this cycle
    assign issue_stage_ready = ~stage_valid | (|unit_request);
    assign decode_advance = decode_valid & issue_stage_ready;

    ////////////////////
    // Issue register
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            stage_valid <= 1'b0;
        end else if (issue_stage_ready) begin
            stage_valid <= decode_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_stage_ready) begin
            issue_pc <= decode_pc;
            issue_id <= decode_id;
            issue_rs1 <= decode_instruction.r.rs1;
            issue_rs2 <= decode_instruction.r.rs2;
            issue_rd <= decode_instruction.r.rd;
            issue_unit <= unit_needed;
            issue_uses_rs1 <= uses_rs1;
            issue_uses_rs2 <= uses_rs2;
            issue_uses_rd <= uses_rd;
        end
    end

    ////////////////////
    // Issue decision
    assign operands_ready = ~(issue_uses_rs1 & rs1_busy) & ~(issue_uses_rs2 & rs2_busy);

    assign issue_to = {NUM_UNITS{stage_valid & operands_ready & ~issue_hold & ~exception_pending}}
                      & issue_unit & unit_ready;
    assign unit_request = issue_to & {NUM_UNITS{~flush}};

    // Only multicycle units hold a destination busy
    assign sb_set_en = (|unit_request) & issue_uses_rd & (issue_rd != '0) & ~issue_unit[ALU_ID];
    assign sb_set_rd = issue_rd;

    ////////////////////
    // Constant ALU, LUI and AUIPC results or the link value PC+4
    assign upper_imm = {decode_instruction.u.imm, 12'b0};

    always_ff @(posedge clk) begin
        if (issue_stage_ready) begin
            if (decode_instruction.u.opcode == LUI) begin
                constant_alu <= upper_imm;
            end else if (decode_instruction.u.opcode == AUIPC) begin
                constant_alu <= decode_pc + upper_imm;
            end else begin
                constant_alu <= decode_pc + `XLEN'd4;
            end
        end
    end

    ////////////////////
    // Pre-issue exceptions
    always_comb begin
        case (priv)
            USER:       ecall_code = ECALL_U;
            SUPERVISOR: ecall_code = ECALL_S;
            default:    ecall_code = ECALL_M;
        endcase
    end

    // Zero unit also covers ECALL and EBREAK, sorted out below
    assign illegal_pattern = ~|unit_needed;

    always_comb begin
        if (is_ecall) begin
            decode_code = ecall_code;
            decode_tval = '0;
        end else if (is_ebreak) begin
            decode_code = BREAK;
            decode_tval = '0;
        end else if (illegal_pattern) begin
            decode_code = ILLEGAL_INST;
            decode_tval = decode_instruction;
        end else begin
            // Only meaningful when fetch reported an error
            decode_code = FETCH_FAULT;
            decode_tval = decode_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_stage_ready) begin
            exception_code <= decode_code;
            exception_tval <= decode_tval;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exception_pending <= 1'b0;
        end else if (issue_stage_ready) begin
            exception_pending <= illegal_pattern | ~decode_fetch_ok;
        end
    end

    // One report per faulting instruction, held until a flush replaces it
    assign new_exception = stage_valid & exception_pending & ~exception_raised &
                           ~issue_hold & ~flush;

    always_ff @(posedge clk) begin
        if (rst || flush || issue_stage_ready) begin
            exception_raised <= 1'b0;
        end else if (new_exception) begin
            exception_raised <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exception_valid <= 1'b0;
        end else begin
            exception_valid <= new_exception;
        end
    end

    assign exception_pc = issue_pc;

    ////////////////////
    // Assertions
    unit_request_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(unit_request))
        else $error("unit_request has more than one unit");

    // The faulting instruction must never reach a unit
    no_issue_on_exception: assert property (@(posedge clk) disable iff (rst)
        exception_valid |-> ~|unit_request)
        else $error("unit_request together with exception_valid");

endmodule

// File: logic/reg_scoreboard.sv
// Register scoreboard holding a busy bit per architectural register for issue
`timescale 1ns/1ns
`include "issue_macros.svh"

module reg_scoreboard (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`REG_ADDR_W-1:0] rs1,
    input  logic [`REG_ADDR_W-1:0] rs2,
    input  logic                   set_en,
    input  logic [`REG_ADDR_W-1:0] set_rd,
    input  logic                   wb_valid,
    input  logic [`REG_ADDR_W-1:0] wb_rd,
    output logic                   rs1_busy,
    output logic                   rs2_busy
);

    logic [`NUM_REGS-1:0] busy;

    ////////////////////
    // Busy bits
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            if (wb_valid) begin
                busy[wb_rd] <= 1'b0;
            end
            // Later assignment lets a new issue win over a writeback
            if (set_en) begin
                busy[set_rd] <= 1'b1;
            end
            // x0 is hardwired
            busy[0] <= 1'b0;
        end
    end

    // No bypass, a writeback is seen the cycle after
    assign rs1_busy = busy[rs1];
    assign rs2_busy = busy[rs2];

    ////////////////////
    // Assertions
    // Writebacks only come back for work issued earlier to a multicycle unit
    wb_targets_busy: assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> busy[wb_rd])
        else $error("writeback to register %0d which is not busy", wb_rd);

endmodule

// File: logic/issue_subsystem_top.sv
// Issue subsystem top joining unit decoder, issue stage and register scoreboard
`timescale 1ns/1ns
`include "issue_macros.svh"

module issue_subsystem_top (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             decode_valid,
    input  logic [`XLEN-1:0]                 decode_pc,
    input  issue_pkg::instr_word_u           decode_instruction,
    input  logic [`ID_WIDTH-1:0]             decode_id,
    input  logic                             decode_fetch_ok,
    output logic                             decode_advance,
    input  logic [issue_pkg::NUM_UNITS-1:0] unit_ready,
    output logic [issue_pkg::NUM_UNITS-1:0] unit_request,
    output logic [`ID_WIDTH-1:0]             issue_id,
    output logic [`REG_ADDR_W-1:0]           issue_rs1,
    output logic [`REG_ADDR_W-1:0]           issue_rs2,
    output logic [`REG_ADDR_W-1:0]           issue_rd,
    output logic [`XLEN-1:0]                 constant_alu,
    input  logic                             wb_valid,
    input  logic [`REG_ADDR_W-1:0]           wb_rd,
    input  logic                             flush,
    input  logic                             issue_hold,
    input  issue_pkg::priv_t                 priv,
    output logic                             exception_valid,
    output issue_pkg::exc_code_t             exception_code,
    output logic [`XLEN-1:0]                 exception_tval,
    output logic [`XLEN-1:0]                 exception_pc
);
    import issue_pkg::*;

    logic [NUM_UNITS-1:0]   unit_needed;
    logic                   uses_rs1;
    logic                   uses_rs2;
    logic                   uses_rd;
    logic                   is_ecall;
    logic                   is_ebreak;
    logic                   rs1_busy;
    logic                   rs2_busy;
    logic                   sb_set_en;
    logic [`REG_ADDR_W-1:0] sb_set_rd;

    unit_decoder unit_decoder_inst (
        .instruction (decode_instruction),
        .unit_needed (unit_needed),
        .uses_rs1    (uses_rs1),
        .uses_rs2    (uses_rs2),
        .uses_rd     (uses_rd),
        .is_ecall    (is_ecall),
        .is_ebreak   (is_ebreak)
    );

    decode_and_issue decode_and_issue_inst (.*);

    reg_scoreboard reg_scoreboard_inst (
        .clk      (clk),
        .rst      (rst),
        .rs1      (issue_rs1),
        .rs2      (issue_rs2),
        .set_en   (sb_set_en),
        .set_rd   (sb_set_rd),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .rs1_busy (rs1_busy),
        .rs2_busy (rs2_busy)
    );

endmodule

// File: test/issue_checker.sv
// Issue checker with a reference model of the decode and issue stage and its scoreboard
`timescale 1ns/1ns
`include "issue_macros.svh"

module issue_checker (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   decode_valid,
    input  logic [`XLEN-1:0]       decode_pc,
    input  logic [`XLEN-1:0]       decode_instruction,
    input  logic [`ID_WIDTH-1:0]   decode_id,
    input  logic                   decode_fetch_ok,
    input  logic                   decode_advance,
    input  logic [2:0]             unit_ready,
    input  logic [2:0]             unit_request,
    input  logic [`ID_WIDTH-1:0]   issue_id,
    input  logic [`REG_ADDR_W-1:0] issue_rs1,
    input  logic [`REG_ADDR_W-1:0] issue_rs2,
    input  logic [`REG_ADDR_W-1:0] issue_rd,
    input  logic [`XLEN-1:0]       constant_alu,
    input  logic                   wb_valid,
    input  logic [`REG_ADDR_W-1:0] wb_rd,
    input  logic                   flush,
    input  logic                   issue_hold,
    input  logic [1:0]             priv,
    input  logic                   exception_valid,
    input  logic [3:0]             exception_code,
    input  logic [`XLEN-1:0]       exception_tval,
    input  logic [`XLEN-1:0]       exception_pc
);

    typedef struct packed {
        logic [31:0] word;
        logic [31:0] pc;
        logic [2:0]  id;
        logic        fetch_ok;
        logic [1:0]  priv;
        logic        raised;
    } entry_t;

    entry_t      pending_q[$];
    logic [31:0] busy;
    logic        exc_expected;
    int          test_checks[1:5];
    int          test_errors[1:5];
    int          error_count;

    // {unit one-hot, uses rs1, uses rs2, uses rd}, unit order LS MUL ALU
    function automatic logic [5:0] expected_decode(input logic [31:0] w);
        case (w[6:0])
            7'h37, 7'h17, 7'h6f: return {3'b001, 3'b001};
            7'h67, 7'h13:        return {3'b001, 3'b101};
            7'h63:               return {3'b001, 3'b110};
            7'h33:               return {(w[31:25] == 7'd1) ? 3'b010 : 3'b001, 3'b111};
            7'h03:               return {3'b100, 3'b101};
            7'h23:               return {3'b100, 3'b110};
            default:             return 6'b0;
        endcase
    endfunction

    function automatic logic [31:0] expected_constant(input entry_t e);
        if (e.word[6:0] == 7'h37) begin
            return {e.word[31:12], 12'b0};
        end else if (e.word[6:0] == 7'h17) begin
            return e.pc + {e.word[31:12], 12'b0};
        end
        return e.pc + 32'd4;
    endfunction

    // Exception code and tval by priority: ECALL, EBREAK, illegal, fetch fault
    function automatic logic [35:0] expected_exception(input entry_t e);
        logic [3:0] ecall_code;
        ecall_code = (e.priv == 2'd0) ? 4'd8 : (e.priv == 2'd1) ? 4'd9 : 4'd11;
        if (e.word == 32'h0000_0073) return {ecall_code, 32'd0};
        if (e.word == 32'h0010_0073) return {4'd3, 32'd0};
        if (expected_decode(e.word) == 6'b0) return {4'd2, e.word};
        return {4'd1, e.pc};
    endfunction

    task automatic value_mismatch(input int test, input string name,
                                  input logic [31:0] expected, input logic [31:0] actual);
        $display("[FAIL] test %0d %s: expected 0x%h, got 0x%h", test, name, expected, actual);
        test_errors[test]++;
        error_count++;
    endtask

    task automatic event_failure(input int test, input string text);
        $display("Test %0d failed at %0t: %s", test, $time, text);
        test_errors[test]++;
        error_count++;
    endtask

    task automatic compare(input int test, input string name,
                           input logic [31:0] expected, input logic [31:0] actual);
        test_checks[test]++;
        if (expected !== actual) value_mismatch(test, name, expected, actual);
    endtask

    initial begin
        error_count = 0;
        exc_expected = 1'b0;
        busy = '0;
        for (int t = 1; t <= 5; t++) begin
            test_checks[t] = 0;
            test_errors[t] = 0;
        end
    end

    ////////////////////
    // Cycle model, sampled mid-cycle where all inputs and outputs are settled
    always @(negedge clk) begin : model_step
        entry_t      front;
        logic [5:0]  dec;
        logic [35:0] exc;
        logic        faulting;
        logic        sources_free;
        logic        can_issue;
        logic        issued;
        issued = 1'b0;
        if (rst) begin
            pending_q.delete();
            busy = '0;
            exc_expected = 1'b0;
        end else begin
            compare(4, "exception_valid", {31'b0, exc_expected}, {31'b0, exception_valid});
            if (exc_expected && exception_valid && pending_q.size() > 0) begin
                exc = expected_exception(pending_q[0]);
                compare(4, "exception_code", {28'b0, exc[35:32]}, {28'b0, exception_code});
                compare(4, "exception_tval", exc[31:0], exception_tval);
                compare(4, "exception_pc", pending_q[0].pc, exception_pc);
            end
            exc_expected = 1'b0;
            if (pending_q.size() > 1) event_failure(1, "more than one instruction in the stage");
            if (pending_q.size() > 0) begin
                front = pending_q[0];
                dec = expected_decode(front.word);
                faulting = (dec == 6'b0) || !front.fetch_ok;
                sources_free = !(dec[2] && busy[front.word[19:15]]) &&
                               !(dec[1] && busy[front.word[24:20]]);
                can_issue = !faulting && sources_free && |(dec[5:3] & unit_ready) &&
                            !issue_hold && !flush;
                if (faulting) begin
                    test_checks[4]++;
                    if (unit_request != 3'b0) event_failure(4, "faulting instruction issued");
                    if (!front.raised && !issue_hold && !flush) begin
                        exc_expected = 1'b1;
                        pending_q[0].raised = 1'b1;
                    end
                end else if (unit_request != 3'b0 && !can_issue) begin
                    test_checks[2]++;
                    if (flush) event_failure(5, "issue during a flush");
                    else event_failure(2, "issue with busy source, unit not ready or hold");
                end else if (unit_request == 3'b0 && can_issue) begin
                    test_checks[2]++;
                    event_failure(2, "no issue although all conditions held");
                end else if (unit_request != 3'b0) begin
                    issued = 1'b1;
                    compare(1, "unit_request", {29'b0, dec[5:3]}, {29'b0, unit_request});
                    compare(1, "issue_id", {29'b0, front.id}, {29'b0, issue_id});
                    compare(1, "issue_rs1", {27'b0, front.word[19:15]}, {27'b0, issue_rs1});
                    compare(1, "issue_rs2", {27'b0, front.word[24:20]}, {27'b0, issue_rs2});
                    compare(1, "issue_rd", {27'b0, front.word[11:7]}, {27'b0, issue_rd});
                    compare(3, "constant_alu", expected_constant(front), constant_alu);
                    void'(pending_q.pop_front());
                end
                if (issued && !dec[3] && dec[0] && front.word[11:7] != 5'd0) begin
                    // Multicycle result, set wins over a writeback below
                    if (wb_valid) busy[wb_rd] = 1'b0;
                    busy[front.word[11:7]] = 1'b1;
                end else if (wb_valid) begin
                    busy[wb_rd] = 1'b0;
                end
            end else begin
                if (unit_request != 3'b0) event_failure(5, "issue from an empty stage");
                if (wb_valid) busy[wb_rd] = 1'b0;
            end
            compare(5, "decode_advance",
                    {31'b0, decode_valid && (pending_q.size() == 0)}, {31'b0, decode_advance});
            if (flush) begin
                pending_q.delete();
            end else if (decode_valid && decode_advance) begin
                pending_q.push_back({decode_instruction, decode_pc, decode_id,
                                     decode_fetch_ok, priv, 1'b0});
            end
        end
    end

    function automatic int pending_count();
        return pending_q.size();
    endfunction

    task automatic report_results();
        $display("Test 1 issue order and fields: %0d checks, %0d errors",
                 test_checks[1], test_errors[1]);
        $display("Test 2 hazard, ready and hold: %0d checks, %0d errors",
                 test_checks[2], test_errors[2]);
        $display("Test 3 constant ALU: %0d checks, %0d errors", test_checks[3], test_errors[3]);
        $display("Test 4 exceptions: %0d checks, %0d errors", test_checks[4], test_errors[4]);
        $display("Test 5 flush and advance: %0d checks, %0d errors",
                 test_checks[5], test_errors[5]);
        $display("Totals: %0d checks, %0d errors", test_checks[1] + test_checks[2] +
                 test_checks[3] + test_checks[4] + test_checks[5], error_count);
    endtask

endmodule

// File: test/issue_tb.sv
// Issue testbench driving random instructions, unit readiness, writebacks and flushes
`timescale 1ns/1ns
`include "issue_macros.svh"

module issue_tb;

    localparam int NUM_INSTR = 300;
    localparam int RESET_CYCLES = 5;
    localparam int CYCLE_LIMIT = 20 * NUM_INSTR + RESET_CYCLES;

    logic                   clk;
    logic                   rst;
    logic                   decode_valid;
    logic [`XLEN-1:0]       decode_pc;
    logic [`XLEN-1:0]       decode_instruction;
    logic [`ID_WIDTH-1:0]   decode_id;
    logic                   decode_fetch_ok;
    logic                   decode_advance;
    logic [2:0]             unit_ready;
    logic [2:0]             unit_request;
    logic [`ID_WIDTH-1:0]   issue_id;
    logic [`REG_ADDR_W-1:0] issue_rs1;
    logic [`REG_ADDR_W-1:0] issue_rs2;
    logic [`REG_ADDR_W-1:0] issue_rd;
    logic [`XLEN-1:0]       constant_alu;
    logic                   wb_valid;
    logic [`REG_ADDR_W-1:0] wb_rd;
    logic                   flush;
    logic                   issue_hold;
    issue_pkg::priv_t       priv;
    logic                   exception_valid;
    issue_pkg::exc_code_t   exception_code;
    logic [`XLEN-1:0]       exception_tval;
    logic [`XLEN-1:0]       exception_pc;
    logic                   taken;
    int                     cycles;
    int                     sent;

    issue_subsystem_top issue_subsystem_top_inst (.*);

    issue_checker checker_inst (.*);

    always #50 clk = ~clk;

    // Fetch sees its hand-off in the middle of the cycle
    always @(negedge clk) taken = decode_valid & decode_advance;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Errors found");
            $finish;
        end
    end

    // Small register range so hazards come up often
    function automatic logic [31:0] random_instruction();
        logic [6:0] f7;
        logic [6:0] op;
        logic [2:0] f3;
        int         kind;
        kind = $urandom_range(0, 19);
        f7 = 7'($urandom);
        f3 = 3'($urandom);
        case (kind)
            0:             op = 7'h37;
            1:             op = 7'h17;
            2:             op = 7'h6f;
            3:             op = 7'h67;
            4:             op = 7'h63;
            5, 6:          op = 7'h03;
            7:             op = 7'h23;
            8, 18, 19:     op = 7'h13;
            14:            return 32'h0000_0073;
            15:            return 32'h0010_0073;
            16: begin
                op = 7'h73;
                f3 = 3'd1;
            end
            17:            op = 7'h7f;
            default: begin
                op = 7'h33;
                f7 = (kind >= 11) ? 7'd1 : ((kind == 9) ? 7'd0 : 7'h20);
            end
        endcase
        return {f7, 2'b0, 3'($urandom_range(0, 7)), 2'b0, 3'($urandom_range(0, 7)),
                f3, 2'b0, 3'($urandom_range(0, 7)), op};
    endfunction

    task automatic drive_controls();
        logic [4:0] candidates[$];
        unit_ready = 3'($urandom_range(0, 7));
        issue_hold = ($urandom_range(0, 7) == 0);
        flush = ($urandom_range(0, 39) == 0);
        case ($urandom_range(0, 2))
            0:       priv = issue_pkg::USER;
            1:       priv = issue_pkg::SUPERVISOR;
            default: priv = issue_pkg::MACHINE;
        endcase
        // Writebacks only for registers held busy by an issued MUL or LS
        for (int r = 1; r < `NUM_REGS; r++) begin
            if (checker_inst.busy[r]) candidates.push_back(5'(r));
        end
        wb_valid = 1'b0;
        wb_rd = '0;
        if (candidates.size() > 0 && $urandom_range(0, 2) == 0) begin
            wb_valid = 1'b1;
            wb_rd = candidates[$urandom_range(0, candidates.size() - 1)];
        end
    endtask

    initial begin
        void'($urandom(32'hed6c_cec3));
        clk = 1'b0;
        rst = 1'b1;
        decode_valid = 1'b0;
        decode_pc = '0;
        decode_instruction = '0;
        decode_id = '0;
        decode_fetch_ok = 1'b1;
        unit_ready = '0;
        wb_valid = 1'b0;
        wb_rd = '0;
        flush = 1'b0;
        issue_hold = 1'b0;
        priv = issue_pkg::MACHINE;
        taken = 1'b0;
        cycles = 0;
        sent = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        rst = 1'b0;
        while (sent < NUM_INSTR || decode_valid || checker_inst.pending_count() != 0) begin
            if (taken || !decode_valid) begin
                if (sent < NUM_INSTR) begin
                    decode_valid = 1'b1;
                    decode_pc = {30'($urandom_range(0, 32'h3fff_ffff)), 2'b00};
                    decode_instruction = random_instruction();
                    decode_id = sent[`ID_WIDTH-1:0];
                    decode_fetch_ok = ($urandom_range(0, 19) != 0);
                    sent++;
                end else begin
                    decode_valid = 1'b0;
                end
            end
            drive_controls();
            @(posedge clk);
            #10;
        end
        flush = 1'b0;
        wb_valid = 1'b0;
        repeat (3) @(posedge clk);
        checker_inst.report_results();
        if (checker_inst.error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+common
common/issue_pkg.sv
decode_issue/unit_decoder.sv
decode_issue/decode_and_issue.sv
logic/reg_scoreboard.sv
logic/issue_subsystem_top.sv
test/issue_checker.sv
test/issue_tb.sv

// File: Makefile
SRCS := $(wildcard common/*.sv common/*.svh decode_issue/*.sv logic/*.sv test/*.sv)

.PHONY: run clean

run: obj_dir/Vissue_tb
	./obj_dir/Vissue_tb | tee /dev/stderr | grep -q "^No errors$$"

obj_dir/Vissue_tb: tb.f $(SRCS)
	verilator --binary --timing --assert -f tb.f --top-module issue_tb -o Vissue_tb

clean:
	rm -rf obj_dir
